/* logic/tcpStreamPkg.sv */
package tcpStreamPkg;

	////////////////////////////////////////
	// basic widths
	////////////////////////////////////////

	typedef logic [7:0]  byteT;
	typedef logic [31:0] ipAddrT;
	typedef logic [15:0] portT;
	typedef logic [15:0] lengthT;	// ip total length, payload remaining

	// which header field the walker is presenting
	typedef enum logic [2:0] {
		fieldNone    = 3'd0,
		fieldSrcIp   = 3'd1,
		fieldDstIp   = 3'd2,
		fieldSrcPort = 3'd3,
		fieldDstPort = 3'd4
	} fieldSelT;

	// walker states, each counting bytes within its section
	typedef enum logic [6:0] {
		walkIdle     = 7'd0,
		walkMac      = 7'd1,	// dst + src mac, 12 bytes
		walkType0    = 7'd2,
		walkType1    = 7'd3,
		walkVlan     = 7'd4,	// rest of 802.1Q tag
		walkIpFixed  = 7'd5,
		walkIpOpt    = 7'd6,
		walkTcpFixed = 7'd7,
		walkTcpOpt   = 7'd8,
		walkPayload  = 7'd9
	} walkStateT;

	////////////////////////////////////////
	// protocol constants
	////////////////////////////////////////

	parameter byteT etherTypeIpv4Hi = 8'h08;
	parameter byteT etherTypeIpv4Lo = 8'h00;
	parameter byteT etherTypeVlanHi = 8'h81;	// 0x8100 tpid

	parameter byteT ipProtoTcp = 8'h06;

	// 20 bytes ip + 20 bytes tcp, no options
	parameter lengthT ipTcpBaseHeaderBytes = 16'd40;

	parameter logic [3:0] tcpBaseDataOffset = 4'd5;
	parameter logic [3:0] ipBaseHeaderWords = 4'd5;	// ihl with no options

	parameter int defaultNumSessions = 4;

endpackage

/* logic/headerFieldIf.sv */
interface headerFieldIf;
	import tcpStreamPkg::*;

	// one byte of an address or port field per valid cycle
	logic       fieldValid;
	fieldSelT   fieldSel;
	logic [1:0] byteIndex;	// 0 = most significant byte
	byteT       fieldByte;

	modport walker (
		output fieldValid,
		output fieldSel,
		output byteIndex,
		output fieldByte
	);

	modport matcher (
		input fieldValid,
		input fieldSel,
		input byteIndex,
		input fieldByte
	);

endinterface

/* logic/headerWalker.sv */
module headerWalker (
	input  logic                CLOCK,
	input  logic                rstN,
	input  logic                newPkt,
	input  logic                dataValid,
	input  tcpStreamPkg::byteT  data,
	headerFieldIf.walker        fieldBus,
	output tcpStreamPkg::byteT  payloadByte,
	output logic                payloadValid,
	output logic                headerDone
);
	import tcpStreamPkg::*;

	walkStateT  state;
	logic [4:0] byteCnt;	// byte position inside the current section
	logic [3:0] hdrWords;	// ihl, then tcp data offset, counted down over options
	lengthT     remaining;	// payload bytes still to come
	byteT       lenHi;		// upper byte of ip total length

	logic inFrame;
	logic wordEnd;
	logic optLast;
	logic hdrLast;

	assign inFrame = dataValid && !newPkt;
	assign wordEnd = (byteCnt[1:0] == 2'd3);

	// last option word once hdrWords is one above the base size
	// ihl and data offset share the same five word base
	assign optLast = (hdrWords == tcpBaseDataOffset + 4'd1);

	////////////////////////////////////////
	// byte position state machine
	////////////////////////////////////////

	always_ff @(posedge CLOCK or negedge rstN) begin
		if (!rstN) begin
			state     <= walkIdle;
			byteCnt   <= '0;
			hdrWords  <= '0;
			remaining <= '0;
		end else if (newPkt) begin
			state   <= walkMac;
			byteCnt <= dataValid ? 5'd1 : 5'd0;	// strobe byte is mac byte 0
		end else if (dataValid) begin
			byteCnt <= byteCnt + 5'd1;
			case (state)
				walkMac: begin
					if (byteCnt == 5'd11) begin
						state   <= walkType0;
						byteCnt <= '0;
					end
				end
				walkType0: begin
					byteCnt <= '0;
					if (data == etherTypeVlanHi)
						state <= walkVlan;
					else if (data == etherTypeIpv4Hi)
						state <= walkType1;
					else
						state <= walkIdle;
				end
				walkType1: begin
					byteCnt <= '0;
					state   <= (data == etherTypeIpv4Lo) ? walkIpFixed : walkIdle;
				end
				walkVlan: begin
					// tpid low byte and tci, then another ethertype
					if (byteCnt == 5'd2) begin
						state   <= walkType0;
						byteCnt <= '0;
					end
				end
				walkIpFixed: begin
					if (byteCnt == 5'd0)
						hdrWords <= data[3:0];
					if (byteCnt == 5'd3)
						remaining <= {lenHi, data} - ipTcpBaseHeaderBytes;
					if (byteCnt == 5'd9 && data != ipProtoTcp)
						state <= walkIdle;
					if (byteCnt == 5'd19) begin
						byteCnt <= '0;
						state   <= (hdrWords == ipBaseHeaderWords) ? walkTcpFixed : walkIpOpt;
					end
				end
				walkIpOpt: begin
					remaining <= remaining - 16'd1;	// options were counted as payload
					if (wordEnd) begin
						hdrWords <= hdrWords - 4'd1;
						byteCnt  <= '0;
						if (optLast)
							state <= walkTcpFixed;
					end
				end
				walkTcpFixed: begin
					if (byteCnt == 5'd12)
						hdrWords <= data[7:4];	// data offset
					if (byteCnt == 5'd19) begin
						byteCnt <= '0;
						if (hdrWords != tcpBaseDataOffset)
							state <= walkTcpOpt;
						else if (remaining != '0)
							state <= walkPayload;
						else
							state <= walkIdle;
					end
				end
				walkTcpOpt: begin
					remaining <= remaining - 16'd1;
					if (wordEnd) begin
						hdrWords <= hdrWords - 4'd1;
						byteCnt  <= '0;
						if (optLast)
							state <= (remaining != 16'd1) ? walkPayload : walkIdle;
					end
				end
				walkPayload: begin
					remaining <= remaining - 16'd1;
					if (remaining == 16'd1)
						state <= walkIdle;
				end
				default: begin
					byteCnt <= '0;	// wait for next frame
				end
			endcase
		end
	end

	always_ff @(posedge CLOCK) begin
		if (dataValid && state == walkIpFixed && byteCnt == 5'd2)
			lenHi <= data;
	end

	////////////////////////////////////////
	// outputs
	////////////////////////////////////////

	// header finished with payload to follow
	assign hdrLast = (state == walkTcpFixed && byteCnt == 5'd19
			&& hdrWords == tcpBaseDataOffset && remaining != '0)
		|| (state == walkTcpOpt && wordEnd && optLast && remaining != 16'd1);

	assign headerDone   = inFrame && hdrLast;
	assign payloadByte  = data;
	assign payloadValid = inFrame && (state == walkPayload);

	always_comb begin
		fieldBus.fieldValid = 1'b0;
		fieldBus.fieldSel   = fieldNone;
		fieldBus.byteIndex  = byteCnt[1:0];
		fieldBus.fieldByte  = data;
		if (inFrame && state == walkIpFixed && byteCnt >= 5'd12) begin
			fieldBus.fieldValid = 1'b1;
			fieldBus.fieldSel   = (byteCnt < 5'd16) ? fieldSrcIp : fieldDstIp;
		end
		if (inFrame && state == walkTcpFixed && byteCnt < 5'd4) begin
			fieldBus.fieldValid = 1'b1;
			fieldBus.fieldSel   = byteCnt[1] ? fieldDstPort : fieldSrcPort;
			fieldBus.byteIndex  = {1'b0, byteCnt[0]};	// ports are two bytes
		end
	end

endmodule

/* logic/sessionMatcher.sv */
module sessionMatcher #(
	parameter int numSessions = tcpStreamPkg::defaultNumSessions
) (
	input  logic                   CLOCK,
	input  logic                   rstN,
	headerFieldIf.matcher          fieldBus,
	input  tcpStreamPkg::ipAddrT   sessSrcIp [numSessions],
	input  tcpStreamPkg::ipAddrT   sessDstIp [numSessions],
	input  tcpStreamPkg::portT     sessSrcPort [numSessions],
	input  tcpStreamPkg::portT     sessDstPort [numSessions],
	output logic [numSessions-1:0] matchVector,
	output tcpStreamPkg::ipAddrT   tcpSrcIp,
	output tcpStreamPkg::ipAddrT   tcpDstIp,
	output tcpStreamPkg::portT     tcpSrcPort,
	output tcpStreamPkg::portT     tcpDstPort
);
	import tcpStreamPkg::*;

	// flags 0-3 src ip, 4-7 dst ip, 8-9 src port, 10-11 dst port
	logic [11:0] cmpFlags [numSessions];
	byteT        expByte [numSessions];
	logic [3:0]  flagBase;
	logic [3:0]  flagIdx;
	logic [4:0]  ipShift;
	logic [3:0]  portShift;

	assign ipShift   = {~fieldBus.byteIndex, 3'b000};
	assign portShift = {~fieldBus.byteIndex[0], 3'b000};
	assign flagIdx   = flagBase + {2'b00, fieldBus.byteIndex};

	always_comb begin
		case (fieldBus.fieldSel)
			fieldDstIp:   flagBase = 4'd4;
			fieldSrcPort: flagBase = 4'd8;
			fieldDstPort: flagBase = 4'd10;
			default:      flagBase = 4'd0;
		endcase
	end

	// the table byte each session expects at this position
	always_comb begin
		for (int s = 0; s < numSessions; s++) begin
			case (fieldBus.fieldSel)
				fieldSrcIp:   expByte[s] = sessSrcIp[s][ipShift +: 8];
				fieldDstIp:   expByte[s] = sessDstIp[s][ipShift +: 8];
				fieldSrcPort: expByte[s] = sessSrcPort[s][portShift +: 8];
				default:      expByte[s] = sessDstPort[s][portShift +: 8];
			endcase
		end
	end

	always_ff @(posedge CLOCK or negedge rstN) begin
		if (!rstN) begin
			for (int s = 0; s < numSessions; s++)
				cmpFlags[s] <= '0;
		end else if (fieldBus.fieldValid) begin
			for (int s = 0; s < numSessions; s++)
				cmpFlags[s][flagIdx] <= (fieldBus.fieldByte == expByte[s]);
		end
	end

	always_comb begin
		for (int s = 0; s < numSessions; s++)
			matchVector[s] = &cmpFlags[s];	// all twelve bytes equal
	end

	////////////////////////////////////////
	// four-tuple of the current frame
	////////////////////////////////////////

	always_ff @(posedge CLOCK) begin
		if (fieldBus.fieldValid) begin
			case (fieldBus.fieldSel)
				fieldSrcIp:   tcpSrcIp[ipShift +: 8] <= fieldBus.fieldByte;
				fieldDstIp:   tcpDstIp[ipShift +: 8] <= fieldBus.fieldByte;
				fieldSrcPort: tcpSrcPort[portShift +: 8] <= fieldBus.fieldByte;
				fieldDstPort: tcpDstPort[portShift +: 8] <= fieldBus.fieldByte;
				default: ;
			endcase
		end
	end

endmodule

/* logic/payloadSteer.sv */
module payloadSteer #(
	parameter int numSessions = tcpStreamPkg::defaultNumSessions
) (
	input  logic                   CLOCK,
	input  logic                   rstN,
	input  tcpStreamPkg::byteT     payloadByte,
	input  logic                   payloadValid,
	input  logic                   headerDone,
	input  logic [numSessions-1:0] matchVector,
	output tcpStreamPkg::byteT     outData,
	output logic                   outPayload,
	output logic                   outNewPkt,
	output logic [numSessions-1:0] outMatch
);

	////////////////////////////////////////
	// one register stage to the outputs
	////////////////////////////////////////

	always_ff @(posedge CLOCK or negedge rstN) begin
		if (!rstN) begin
			outPayload <= 1'b0;
			outNewPkt  <= 1'b0;
			outMatch   <= '0;
		end else begin
			outPayload <= payloadValid;
			outNewPkt  <= headerDone;	// last header byte, payload follows
			// session flags only ride on payload bytes
			outMatch   <= payloadValid ? matchVector : '0;
		end
	end

	// data byte follows the input every cycle
	always_ff @(posedge CLOCK) begin
		outData <= payloadByte;
	end

endmodule

/* logic/tcpStream.sv */
module tcpStream #(
	parameter int numSessions = tcpStreamPkg::defaultNumSessions
) (
	input  logic                   CLOCK,
	input  logic                   rstN,
	input  logic                   newPkt,
	input  logic                   dataValid,
	input  tcpStreamPkg::byteT     data,
	input  tcpStreamPkg::ipAddrT   sessSrcIp [numSessions],
	input  tcpStreamPkg::ipAddrT   sessDstIp [numSessions],
	input  tcpStreamPkg::portT     sessSrcPort [numSessions],
	input  tcpStreamPkg::portT     sessDstPort [numSessions],
	output tcpStreamPkg::byteT     outData,
	output logic                   outPayload,
	output logic                   outNewPkt,
	output logic [numSessions-1:0] outMatch,
	output tcpStreamPkg::ipAddrT   tcpSrcIp,
	output tcpStreamPkg::ipAddrT   tcpDstIp,
	output tcpStreamPkg::portT     tcpSrcPort,
	output tcpStreamPkg::portT     tcpDstPort
);
	import tcpStreamPkg::*;

	headerFieldIf fieldBus ();

	byteT                   payloadByte;
	logic                   payloadValid;
	logic                   headerDone;
	logic [numSessions-1:0] matchVector;

	headerWalker walker (
		.CLOCK        (CLOCK),
		.rstN         (rstN),
		.newPkt       (newPkt),
		.dataValid    (dataValid),
		.data         (data),
		.fieldBus     (fieldBus.walker),
		.payloadByte  (payloadByte),
		.payloadValid (payloadValid),
		.headerDone   (headerDone)
	);

	sessionMatcher #(.numSessions(numSessions)) matcher (
		.CLOCK       (CLOCK),
		.rstN        (rstN),
		.fieldBus    (fieldBus.matcher),
		.sessSrcIp   (sessSrcIp),
		.sessDstIp   (sessDstIp),
		.sessSrcPort (sessSrcPort),
		.sessDstPort (sessDstPort),
		.matchVector (matchVector),
		.tcpSrcIp    (tcpSrcIp),
		.tcpDstIp    (tcpDstIp),
		.tcpSrcPort  (tcpSrcPort),
		.tcpDstPort  (tcpDstPort)
	);

	payloadSteer #(.numSessions(numSessions)) steer (
		.CLOCK        (CLOCK),
		.rstN         (rstN),
		.payloadByte  (payloadByte),
		.payloadValid (payloadValid),
		.headerDone   (headerDone),
		.matchVector  (matchVector),
		.outData      (outData),
		.outPayload   (outPayload),
		.outNewPkt    (outNewPkt),
		.outMatch     (outMatch)
	);

endmodule

/* sim/tcpStream_sva.sv */
module tcpStream_sva #(
	parameter int numSessions = tcpStreamPkg::defaultNumSessions
) (
	input logic                   CLOCK,
	input logic                   rstN,
	input logic                   outPayload,
	input logic                   outNewPkt,
	input logic [numSessions-1:0] outMatch
);
	timeunit 1ns;
	timeprecision 1ps;

	// pulse marks the last header byte, never a payload byte
	newPktApart: assert property (@(posedge CLOCK) disable iff (!rstN)
		!(outNewPkt && outPayload))
		else $error("outNewPkt high together with outPayload");

	matchOnPayloadOnly: assert property (@(posedge CLOCK) disable iff (!rstN)
		!outPayload |-> (outMatch == '0))
		else $error("outMatch set without outPayload");

	quietInReset: assert property (@(posedge CLOCK)
		!rstN |-> (!outPayload && !outNewPkt && outMatch == '0))
		else $error("outputs active during reset");

endmodule

bind tcpStream tcpStream_sva #(.numSessions(numSessions)) sva0 (
	.CLOCK      (CLOCK),
	.rstN       (rstN),
	.outPayload (outPayload),
	.outNewPkt  (outNewPkt),
	.outMatch   (outMatch)
);

/* sim/tcpStreamTb.sv */
module tcpStreamTb;
	timeunit 1ns;
	timeprecision 1ps;
	import tcpStreamPkg::*;

	localparam int numSessions   = defaultNumSessions;
	localparam int cyclesPerByte = 200;
	localparam int clockPeriod   = 100;

	logic                   CLOCK;
	logic                   rstN;
	logic                   newPkt;
	logic                   dataValid;
	byteT                   data;
	ipAddrT                 sessSrcIp [numSessions];
	ipAddrT                 sessDstIp [numSessions];
	portT                   sessSrcPort [numSessions];
	portT                   sessDstPort [numSessions];
	byteT                   outData;
	logic                   outPayload;
	logic                   outNewPkt;
	logic [numSessions-1:0] outMatch;
	ipAddrT                 tcpSrcIp;
	ipAddrT                 tcpDstIp;
	portT                   tcpSrcPort;
	portT                   tcpDstPort;

	logic [31:0]            words [0:1023];	// raw test data
	byteT                   expPayload [$];
	logic [numSessions-1:0] expMatch;
	int                     rxCount;
	int                     newPktCount;
	int                     frameWords = 0;
	logic [31:0]            lcgState;

	tcpStream #(.numSessions(numSessions)) dut0 (.*);

	initial begin
		CLOCK = 1'b0;
		forever #(clockPeriod / 2) CLOCK = ~CLOCK;
	end

	function automatic logic [31:0] nextRandom();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	task automatic stopOnError(string msg);
		$display("%s", msg);
		$display("*** FAILED ***");
		$fatal(1, "run stopped at first error");
	endtask

	////////////////////////////////////////
	// compare tasks
	////////////////////////////////////////

	task automatic checkByte(byteT got, byteT exp, int idx);
		if (got !== exp)
			stopOnError($sformatf("MISMATCH at %0t: payload byte %0d is %h, expected %h",
				$time, idx, got, exp));
	endtask

	task automatic checkMatch(logic [numSessions-1:0] got, logic [numSessions-1:0] exp);
		if (got !== exp)
			stopOnError($sformatf("MISMATCH at %0t: outMatch is %b, expected %b",
				$time, got, exp));
	endtask

	task automatic checkTuple(ipAddrT gotSrc, ipAddrT gotDst, portT gotSp, portT gotDp,
			ipAddrT expSrc, ipAddrT expDst, portT expSp, portT expDp);
		if (gotSrc !== expSrc || gotDst !== expDst || gotSp !== expSp || gotDp !== expDp)
			stopOnError($sformatf("MISMATCH at %0t: tuple %h:%h -> %h:%h, expected %h:%h -> %h:%h",
				$time, gotSrc, gotSp, gotDst, gotDp, expSrc, expSp, expDst, expDp));
	endtask

	////////////////////////////////////////
	// stimulus
	////////////////////////////////////////

	task automatic driveCycle(logic first, logic valid, byteT value);
		@(posedge CLOCK);
		#10;
		newPkt    = first;
		dataValid = valid;
		data      = value;
	endtask

	// word 100 in the frame list is an idle cycle
	task automatic playFrame(int start, int count);
		logic        first;
		logic [31:0] r;
		first = 1'b1;
		for (int i = start; i < start + count; i++) begin
			if (words[i] == 32'h100) begin
				driveCycle(1'b0, 1'b0, 8'h00);
			end else begin
				driveCycle(first, 1'b1, words[i][7:0]);
				first = 1'b0;
				r = nextRandom();
				if (r[31:30] == 2'b00)
					driveCycle(1'b0, 1'b0, 8'h00);	// random gap
			end
		end
		driveCycle(1'b0, 1'b0, 8'h00);
	endtask

	// outputs are sampled half a cycle after the edge
	always @(negedge CLOCK) begin
		if (rstN && outNewPkt)
			newPktCount++;
		if (rstN && outPayload) begin
			if (newPktCount != 1) begin
				stopOnError($sformatf("Error at %0t: payload byte seen after %0d new-payload pulses",
					$time, newPktCount));
			end else if (rxCount >= expPayload.size()) begin
				stopOnError($sformatf("Error at %0t: more payload bytes than the %0d expected",
					$time, expPayload.size()));
			end else begin
				checkByte(outData, expPayload[rxCount], rxCount);
				checkMatch(outMatch, expMatch);
				rxCount++;
			end
		end
	end

	initial begin
		int ptr;
		int nWords;
		int nPay;
		int frameStart;
		int recIdx;
		newPkt      = 1'b0;
		dataValid   = 1'b0;
		data        = 8'h00;
		rstN        = 1'b0;
		rxCount     = 0;
		newPktCount = 0;
		expMatch    = '0;
		lcgState    = 32'hf76dc80b;
		$readmemh("sim/testdataFrames.txt", words);
		for (int s = 0; s < numSessions; s++) begin
			sessSrcIp[s]   = words[4*s];
			sessDstIp[s]   = words[4*s + 1];
			sessSrcPort[s] = words[4*s + 2][15:0];
			sessDstPort[s] = words[4*s + 3][15:0];
		end

		// first pass only sizes the watchdog
		ptr = 4 * numSessions;
		while (words[ptr] != 32'hffffffff) begin
			frameWords += words[ptr];
			ptr += words[ptr] + 1;
			ptr += words[ptr] + 6;	// payload, match, tuple
		end
		if (frameWords == 0)
			stopOnError("Error: no frames were read from the test data file");

		repeat (5) @(posedge CLOCK);
		#10;
		rstN = 1'b1;

		ptr    = 4 * numSessions;
		recIdx = 0;
		while (words[ptr] != 32'hffffffff) begin
			nWords     = words[ptr];
			frameStart = ptr + 1;
			ptr        = frameStart + nWords;
			nPay       = words[ptr];
			expPayload.delete();
			for (int i = 0; i < nPay; i++)
				expPayload.push_back(words[ptr + 1 + i][7:0]);
			ptr        += nPay + 1;
			expMatch    = words[ptr][numSessions-1:0];
			rxCount     = 0;
			newPktCount = 0;
			playFrame(frameStart, nWords);
			while (rxCount < nPay)
				@(posedge CLOCK);
			repeat (2) @(posedge CLOCK);	// one cycle latency, catch strays
			if (newPktCount != ((nPay > 0) ? 1 : 0))
				stopOnError($sformatf("Error at %0t: frame %0d gave %0d new-payload pulses",
					$time, recIdx, newPktCount));
			else
				checkTuple(tcpSrcIp, tcpDstIp, tcpSrcPort, tcpDstPort,
					words[ptr + 1], words[ptr + 2], words[ptr + 3][15:0], words[ptr + 4][15:0]);
			ptr += 5;
			recIdx++;
		end
		$display("*** PASSED ***");
		$finish;
	end

	// watchdog, sized once the frames are counted and reset is released
	initial begin
		wait (rstN);
		#(frameWords * cyclesPerByte * clockPeriod);
		stopOnError("Timeout: the frames were not all processed in time");
	end

endmodule

/* sim/testdataFrames.txt */
// session table: srcIp dstIp srcPort dstPort for sessions 0 to 3, two per line
// record: word count, frame bytes (100 = idle cycle), then payload count,
// payload bytes, match vector, srcIp dstIp srcPort dstPort; all values hex
c0a80001 c0a80002 1000 2000  0a000001 0a000002 0050 c350
c0a8010a c0a80114 1f90 d431  ac100001 ac100002 01bb 8001
// plain tcp, session 2
3b 00 11 22 33 44 55 66 77 88 99 aa bb 08 00 100
45 00 00 2c 00 01 40 00 40 06 00 00 c0 a8 01 0a c0 a8 01 14
1f 90 d4 31 00 00 00 01 00 00 00 00 50 18 ff ff 00 00 00 00 de ad be ef
4 de ad be ef  4  c0a8010a c0a80114 1f90 d431
// two vlan tags, ip and tcp options, no session
49 00 11 22 33 44 55 66 77 88 99 aa bb 81 00 00 64 81 00 00 c8 08 00
46 00 00 33 00 02 40 00 40 06 00 00 0a 00 00 01 0a 00 00 03 01 01 01 00
00 50 c3 50 00 00 00 10 00 00 00 00 60 18 ff ff 00 00 00 00 02 04 05 b4 01 02 03
3 01 02 03  0  0a000001 0a000003 0050 c350
// arp, ipv6 and udp leave the tuple alone
12 ff ff ff ff ff ff 66 77 88 99 aa bb 08 06 00 01 08 00
0  0  0a000001 0a000003 0050 c350
12 00 11 22 33 44 55 66 77 88 99 aa bb 86 dd 60 00 00 00
0  0  0a000001 0a000003 0050 c350
2a 00 11 22 33 44 55 66 77 88 99 aa bb 08 00
45 00 00 24 00 03 40 00 40 11 00 00 c0 a8 00 01 c0 a8 00 02 10 00 20 00 00 10 00 00
0  0  0a000001 0a000003 0050 c350
// syn with no payload
36 00 11 22 33 44 55 66 77 88 99 aa bb 08 00
45 00 00 28 00 04 40 00 40 06 00 00 c0 a8 00 01 c0 a8 00 02
10 00 20 00 00 00 00 64 00 00 00 00 50 02 ff ff 00 00 00 00
0  0  c0a80001 c0a80002 1000 2000
ffffffff

/* files.f */
logic/tcpStreamPkg.sv
logic/headerFieldIf.sv
logic/headerWalker.sv
logic/sessionMatcher.sv
logic/payloadSteer.sv
logic/tcpStream.sv
sim/tcpStream_sva.sv
sim/tcpStreamTb.sv

/* run.sh */
#!/bin/sh
# compile and run the tcpStream testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tcpStreamTb -f files.f -Mdir obj_dir -o tcpStreamTb

./obj_dir/tcpStreamTb 2>&1 | tee sim.log

if grep -qx '\*\*\* PASSED \*\*\*' sim.log; then
	exit 0
fi
exit 1
